//--- hdl/line_arbiter.sv
// line grants for modes 2 and 3 only; pipes must hold vld low while their grant is low
`timescale 1ns/1ps
`default_nettype none

module line_arbiter (
   input  wire                   aggre_clk,
   input  wire                   aggre_clk_rst_n,
   input  wire sch_cfg_pkg::sch_mode_e aggre_mode,
   input  wire sch_cfg_pkg::pipe_vec_t aggre_en,
   input  wire sch_cfg_pkg::pipe_vec_t empty,
   input  wire sch_cfg_pkg::pipe_vec_t in_video_data_vld,
   input  wire sch_cfg_pkg::pipe_vec_t line_end,
   output sch_cfg_pkg::pipe_vec_t      up_state,
   output logic                        aggre_busy
);

   import sch_cfg_pkg::*;

   logic      fixed_mode;
   logic      async_mode;
   pipe_vec_t eligible;
   pipe_vec_t grant_q;
   pipe_vec_t async_q;
   pipe_idx_t last_idx;
   pipe_idx_t next_idx;
   logic      found;

   assign fixed_mode = (aggre_mode == mode_aggre_fixed);
   assign async_mode = (aggre_mode == mode_aggre_async);
   assign eligible   = aggre_en & ~empty;

   // circular search starting just after the last granted pipe
   always_comb begin
      next_idx = last_idx;
      found    = 1'b0;
      for (int i = 1; i <= num_pipes; i++) begin
         if (!found && eligible[(int'(last_idx) + i) % num_pipes]) begin
            next_idx = pipe_idx_t'((int'(last_idx) + i) % num_pipes);
            found    = 1'b1;
         end
      end
   end

   // fixed mode, one whole line per grant
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         grant_q  <= '0;
         last_idx <= pipe_idx_t'(num_pipes - 1);
      end else if (!fixed_mode) begin
         grant_q <= '0;
      end else if (|grant_q) begin
         // release after the last word of the line
         if (|(grant_q & line_end & in_video_data_vld)) begin
            grant_q <= '0;
         end
      end else if (found) begin
         grant_q  <= pipe_vec_t'(1) << next_idx;
         last_idx <= next_idx;
      end
   end

   // async mode grants every pipe holding a line
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         async_q <= '0;
      end else begin
         async_q <= ~empty;
      end
   end

   assign up_state   = fixed_mode ? grant_q :
                       async_mode ? async_q : '0;
   assign aggre_busy = fixed_mode & (|grant_q);

endmodule

`default_nettype wire

//--- hdl/pipe_sch.sv
// eight-pipe output scheduler; modes 0 and 1 are off and the output has no back-pressure
`timescale 1ns/1ps
`default_nettype none

module pipe_sch #(
   parameter logic [1:0] aggr_id = 2'd0
) (
   input  wire                          aggre_clk,
   input  wire                          aggre_clk_rst_n,
   input  wire sch_cfg_pkg::sch_mode_e  aggre_mode,
   input  wire sch_cfg_pkg::pipe_vec_t  aggre_en,
   input  wire sch_cfg_pkg::pipe_vec_t  empty,
   input  wire sch_cfg_pkg::pipe_vec_t  in_video_data_vld,
   input  wire video_word_pkg::video_word_t in_video_data [sch_cfg_pkg::num_pipes],
   input  wire sch_cfg_pkg::pipe_vec_t  line_end,
   output sch_cfg_pkg::pipe_vec_t       up_state,
   output logic                         aggre_busy,
   output logic                         out_video_data_vld,
   output video_word_pkg::video_word_t  out_video_data,
   output sch_cfg_pkg::sch_state_e      sch_current_state
);

   // grants go to the pipes and feed the mux and the tracker
   line_arbiter u_line_arbiter (
      .aggre_clk         (aggre_clk),
      .aggre_clk_rst_n   (aggre_clk_rst_n),
      .aggre_mode        (aggre_mode),
      .aggre_en          (aggre_en),
      .empty             (empty),
      .in_video_data_vld (in_video_data_vld),
      .line_end          (line_end),
      .up_state          (up_state),
      .aggre_busy        (aggre_busy)
   );

   video_out_mux #(
      .aggr_id (aggr_id)
   ) u_video_out_mux (
      .aggre_clk          (aggre_clk),
      .aggre_clk_rst_n    (aggre_clk_rst_n),
      .aggre_mode         (aggre_mode),
      .up_state           (up_state),
      .in_video_data_vld  (in_video_data_vld),
      .in_video_data      (in_video_data),
      .out_video_data_vld (out_video_data_vld),
      .out_video_data     (out_video_data)
   );

   sch_state_tracker u_sch_state_tracker (
      .aggre_clk         (aggre_clk),
      .aggre_clk_rst_n   (aggre_clk_rst_n),
      .up_state          (up_state),
      .sch_current_state (sch_current_state)
   );

endmodule

`default_nettype wire

//--- hdl/sch_cfg_pkg.sv
// scheduler configuration types; num_pipes is assumed to be a power of two up to 8
`default_nettype none

package sch_cfg_pkg;

   localparam int num_pipes  = 8;
   localparam int pipe_idx_w = $clog2(num_pipes);

   // one bit per video pipe
   typedef logic [num_pipes-1:0]  pipe_vec_t;
   typedef logic [pipe_idx_w-1:0] pipe_idx_t;

   // mode_concat is not implemented and behaves like mode_off
   typedef enum logic [1:0] {
      mode_off         = 2'd0,
      mode_concat      = 2'd1,
      mode_aggre_fixed = 2'd2,
      mode_aggre_async = 2'd3
   } sch_mode_e;

   // debug view of the last granted pipe
   typedef enum logic [3:0] {
      sch_idle  = 4'd0,
      sch_pipe0 = 4'd1,
      sch_pipe1 = 4'd2,
      sch_pipe2 = 4'd3,
      sch_pipe3 = 4'd4,
      sch_pipe4 = 4'd5,
      sch_pipe5 = 4'd6,
      sch_pipe6 = 4'd7,
      sch_pipe7 = 4'd8
   } sch_state_e;

endpackage

`default_nettype wire

//--- hdl/sch_state_tracker.sv
// debug only; leaves sch_idle on the first grant and returns there only through reset
`timescale 1ns/1ps
`default_nettype none

module sch_state_tracker (
   input  wire                         aggre_clk,
   input  wire                         aggre_clk_rst_n,
   input  wire sch_cfg_pkg::pipe_vec_t up_state,
   output sch_cfg_pkg::sch_state_e     sch_current_state
);

   import sch_cfg_pkg::*;

   sch_state_e next_state;

   // lowest granted pipe other than the current one
   always_comb begin
      next_state = sch_current_state;
      for (int i = num_pipes - 1; i >= 0; i--) begin
         if (up_state[i] && (sch_current_state != sch_state_e'(i + 1))) begin
            next_state = sch_state_e'(i + 1);
         end
      end
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         sch_current_state <= sch_idle;
      end else begin
         sch_current_state <= next_state;
      end
   end

endmodule

`default_nettype wire

//--- hdl/video_out_mux.sv
// output word select; aggr_id is 0 to 3 and matched against the zero-extended stream-ID field
`timescale 1ns/1ps
`default_nettype none

module video_out_mux #(
   parameter logic [1:0] aggr_id = 2'd0
) (
   input  wire                          aggre_clk,
   input  wire                          aggre_clk_rst_n,
   input  wire sch_cfg_pkg::sch_mode_e  aggre_mode,
   input  wire sch_cfg_pkg::pipe_vec_t  up_state,
   input  wire sch_cfg_pkg::pipe_vec_t  in_video_data_vld,
   input  wire video_word_pkg::video_word_t in_video_data [sch_cfg_pkg::num_pipes],
   output logic                         out_video_data_vld,
   output video_word_pkg::video_word_t  out_video_data
);

   import sch_cfg_pkg::*;
   import video_word_pkg::*;

   pipe_vec_t   fix_sel;
   video_word_t fix_word;
   logic        act_vld;
   video_word_t act_word;
   logic        nxt_vld;
   video_word_t nxt_word;

   // fixed mode, only the granted pipe may be valid
   assign fix_sel = up_state & in_video_data_vld;

   always_comb begin
      fix_word = '0;
      for (int i = 0; i < num_pipes; i++) begin
         if (fix_sel[i]) begin
            fix_word = in_video_data[i];
         end
      end
   end

   // async mode, lowest pipe with our stream ID wins
   always_comb begin
      act_vld  = 1'b0;
      act_word = '0;
      for (int i = num_pipes - 1; i >= 0; i--) begin
         if (in_video_data_vld[i] &&
             (in_video_data[i][stream_id_lsb +: stream_id_w] == stream_id_t'(aggr_id))) begin
            act_vld  = 1'b1;
            act_word = in_video_data[i];
         end
      end
   end

   always_comb begin
      case (aggre_mode)
         mode_aggre_fixed: begin
            nxt_vld  = |fix_sel;
            nxt_word = fix_word;
         end
         mode_aggre_async: begin
            nxt_vld  = act_vld;
            nxt_word = act_word;
         end
         default: begin
            nxt_vld  = 1'b0;
            nxt_word = '0;
         end
      endcase
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         out_video_data_vld <= 1'b0;
         out_video_data     <= '0;
      end else begin
         out_video_data_vld <= nxt_vld;
         out_video_data     <= nxt_word;
      end
   end

endmodule

`default_nettype wire

//--- hdl/video_word_pkg.sv
// video word layout; the stream-ID field is assumed to sit in the top bits of the word
`default_nettype none

package video_word_pkg;

   localparam int video_data_w  = 140;
   localparam int stream_id_w   = 4;

   // field occupies bits 139:136
   localparam int stream_id_lsb = video_data_w - stream_id_w;

   typedef logic [video_data_w-1:0] video_word_t;
   typedef logic [stream_id_w-1:0]  stream_id_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+verification
hdl/sch_cfg_pkg.sv
hdl/video_word_pkg.sv
hdl/line_arbiter.sv
hdl/video_out_mux.sv
hdl/sch_state_tracker.sv
hdl/pipe_sch.sv
verification/tb_pipe_sch.sv

//--- verification/tb_pipe_model.svh
// expected scheduler behavior from the grant, mux and tracker rules; needs the tb input regs in scope
`ifndef TB_PIPE_MODEL_SVH
`define TB_PIPE_MODEL_SVH

pipe_vec_t   m_grant;
pipe_vec_t   m_async;
int          m_last;
logic        m_out_vld;
video_word_t m_out_word;
sch_state_e  m_state;

task automatic reset_model();
   m_grant    = '0;
   m_async    = '0;
   // search starts at pipe 0 after reset
   m_last     = num_pipes - 1;
   m_out_vld  = 1'b0;
   m_out_word = '0;
   m_state    = sch_idle;
endtask

function automatic pipe_vec_t expected_grants(input sch_mode_e mode);
   case (mode)
      mode_aggre_fixed: return m_grant;
      mode_aggre_async: return m_async;
      default:          return '0;
   endcase
endfunction

function automatic sch_state_e next_debug_state(input sch_state_e cur, input pipe_vec_t up);
   sch_state_e nxt;
   logic       hit;
   nxt = cur;
   hit = 1'b0;
   for (int i = 0; i < num_pipes; i++) begin
      if (!hit && up[i] && (cur != sch_state_e'(i + 1))) begin
         nxt = sch_state_e'(i + 1);
         hit = 1'b1;
      end
   end
   return nxt;
endfunction

// one clock of the scheduler, using the inputs seen before the edge
task automatic advance_model();
   pipe_vec_t up;
   pipe_vec_t elig;
   logic      hit;
   int        idx;
   up         = expected_grants(aggre_mode);
   m_out_vld  = 1'b0;
   m_out_word = '0;
   for (int i = 0; i < num_pipes; i++) begin
      if (!m_out_vld && in_video_data_vld[i] &&
          ((aggre_mode == mode_aggre_fixed && up[i]) ||
           (aggre_mode == mode_aggre_async &&
            in_video_data[i][stream_id_lsb +: stream_id_w] == stream_id_t'(tb_aggr_id)))) begin
         m_out_vld  = 1'b1;
         m_out_word = in_video_data[i];
      end
   end
   m_state = next_debug_state(m_state, up);
   hit     = 1'b0;
   elig    = aggre_en & ~empty;
   if (aggre_mode != mode_aggre_fixed) begin
      m_grant = '0;
   end else if (m_grant != '0) begin
      if ((m_grant & line_end & in_video_data_vld) != '0) begin
         m_grant = '0;
      end
   end else begin
      for (int k = 1; k <= num_pipes; k++) begin
         idx = (m_last + k) % num_pipes;
         if (!hit && elig[idx]) begin
            m_grant = pipe_vec_t'(1) << idx;
            m_last  = idx;
            hit     = 1'b1;
         end
      end
   end
   m_async = ~empty;
endtask

`endif

//--- verification/tb_pipe_sch.sv
// random pipe agents with a cycle model; outputs are checked at the falling edge, aggr_id is 2
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_sch;

   import sch_cfg_pkg::*;
   import video_word_pkg::*;

   localparam logic [1:0] tb_aggr_id = 2'd2;
   localparam int fixed_lines  = 200;
   localparam int lines_per_en = 25;
   localparam int max_len      = 6;
   localparam int max_gap      = 2;
   localparam int max_refill   = 3;
   localparam int async_cycles = 400;
   localparam int off_cycles   = 100;
   localparam int cycle_limit  = 16 + fixed_lines * (max_len * (max_gap + 1) + max_refill + 6)
                                 + async_cycles + 2 * off_cycles + 500;

   logic        aggre_clk;
   logic        aggre_clk_rst_n;
   sch_mode_e   aggre_mode;
   pipe_vec_t   aggre_en;
   pipe_vec_t   empty;
   pipe_vec_t   in_video_data_vld;
   pipe_vec_t   line_end;
   video_word_t in_video_data [num_pipes];
   pipe_vec_t   up_state;
   logic        aggre_busy;
   logic        out_video_data_vld;
   video_word_t out_video_data;
   sch_state_e  sch_current_state;

   // pipe agent state
   pipe_vec_t up_seen;
   int        words_left [num_pipes];
   int        gap [num_pipes];
   int        refill [num_pipes];
   bit        has_line [num_pipes];
   bit        wait_release [num_pipes];
   int        lines_sent;
   int        cycle_cnt;
   int        checks_done;
   int        reset_errs;
   int        grant_errs;
   int        word_errs;
   int        state_errs;
   int        tests_run;
   int        tests_failed;

   `include "tb_pipe_model.svh"

   pipe_sch #(
      .aggr_id (tb_aggr_id)
   ) DUT (
      .aggre_clk          (aggre_clk),
      .aggre_clk_rst_n    (aggre_clk_rst_n),
      .aggre_mode         (aggre_mode),
      .aggre_en           (aggre_en),
      .empty              (empty),
      .in_video_data_vld  (in_video_data_vld),
      .in_video_data      (in_video_data),
      .line_end           (line_end),
      .up_state           (up_state),
      .aggre_busy         (aggre_busy),
      .out_video_data_vld (out_video_data_vld),
      .out_video_data     (out_video_data),
      .sch_current_state  (sch_current_state)
   );

   always #20 aggre_clk = ~aggre_clk;

   task automatic check_word(input string name, input video_word_t exp, input video_word_t act,
                             inout int errs);
      checks_done++;
      if (act !== exp) begin
         errs++;
         $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_grant(input string name, input pipe_vec_t exp, input pipe_vec_t act,
                              inout int errs);
      checks_done++;
      if (act !== exp) begin
         errs++;
         $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_state(input string name, input sch_state_e exp, input sch_state_e act,
                              inout int errs);
      checks_done++;
      if (act !== exp) begin
         errs++;
         $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act, inout int errs);
      checks_done++;
      if (act !== exp) begin
         errs++;
         $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   function automatic video_word_t rand_word();
      logic [159:0] raw;
      raw = {$urandom, $urandom, $urandom, $urandom, $urandom};
      return raw[video_data_w-1:0];
   endfunction

   task automatic finish_test(input string name, input int errs);
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %0d %-24s %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "failed",
               errs);
   endtask

   // pipes send whole lines while granted, strays only where no grant can be active
   task automatic drive_fixed_cycle(input bit allow_reload);
      pipe_vec_t vld_n;
      pipe_vec_t le_n;
      pipe_vec_t empty_n;
      vld_n   = '0;
      le_n    = '0;
      empty_n = empty;
      for (int p = 0; p < num_pipes; p++) begin
         in_video_data[p] <= rand_word();
         if (wait_release[p]) begin
            if (!up_seen[p]) begin
               wait_release[p] = 1'b0;
            end
         end else if (has_line[p] && up_seen[p]) begin
            if (gap[p] > 0) begin
               gap[p] = gap[p] - 1;
            end else begin
               vld_n[p]      = 1'b1;
               words_left[p] = words_left[p] - 1;
               gap[p]        = $urandom % (max_gap + 1);
               if (words_left[p] == 0) begin
                  le_n[p]         = 1'b1;
                  empty_n[p]      = 1'b1;
                  has_line[p]     = 1'b0;
                  wait_release[p] = 1'b1;
                  lines_sent++;
               end
            end
         end else if (has_line[p]) begin
            if (!aggre_en[p] && ($urandom % 8 == 0)) begin
               vld_n[p] = 1'b1;
            end
         end else begin
            if (!up_seen[p] && ($urandom % 8 == 0)) begin
               vld_n[p] = 1'b1;
            end
            if (allow_reload && refill[p] > 0) begin
               refill[p] = refill[p] - 1;
            end else if (allow_reload) begin
               has_line[p]   = 1'b1;
               words_left[p] = 1 + $urandom % max_len;
               gap[p]        = $urandom % (max_gap + 1);
               refill[p]     = $urandom % (max_refill + 1);
               empty_n[p]    = 1'b0;
            end
         end
      end
      empty             <= empty_n;
      in_video_data_vld <= vld_n;
      line_end          <= le_n;
   endtask

   // stream IDs 0 to 4, so ID 2 and a value above 3 both occur
   task automatic drive_random_cycle();
      video_word_t w;
      aggre_en          <= pipe_vec_t'($urandom);
      empty             <= pipe_vec_t'($urandom);
      in_video_data_vld <= pipe_vec_t'($urandom);
      line_end          <= pipe_vec_t'($urandom);
      for (int p = 0; p < num_pipes; p++) begin
         w = rand_word();
         w[stream_id_lsb +: stream_id_w] = stream_id_t'($urandom % 5);
         in_video_data[p] <= w;
      end
   endtask

   always @(negedge aggre_clk) begin
      if (!aggre_clk_rst_n) begin
         reset_model();
         check_grant("up_state", '0, up_state, reset_errs);
         check_bit("aggre_busy", 1'b0, aggre_busy, reset_errs);
         check_bit("out_video_data_vld", 1'b0, out_video_data_vld, reset_errs);
         check_state("sch_current_state", sch_idle, sch_current_state, reset_errs);
      end else begin
         check_grant("up_state", expected_grants(aggre_mode), up_state, grant_errs);
         check_bit("aggre_busy", (aggre_mode == mode_aggre_fixed) && (m_grant != '0),
                   aggre_busy, grant_errs);
         if (aggre_mode == mode_aggre_fixed && $countones(up_state) > 1) begin
            grant_errs++;
            $display("more than one pipe granted in fixed mode at %0t", $time);
         end
         check_bit("out_video_data_vld", m_out_vld, out_video_data_vld, word_errs);
         if (m_out_vld) begin
            check_word("out_video_data", m_out_word, out_video_data, word_errs);
         end
         check_state("sch_current_state", m_state, sch_current_state, state_errs);
         advance_model();
      end
      up_seen = up_state;
   end

   always @(posedge aggre_clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      int rng_seed;
      int seed_ret;
      int g0;
      int w0;
      int s0;
      int next_en_at;
      rng_seed          = 32'haa0cf1e2;
      seed_ret          = $urandom(rng_seed);
      aggre_clk         = 1'b0;
      aggre_clk_rst_n   = 1'b0;
      aggre_mode        = mode_off;
      aggre_en          = '0;
      empty             = '1;
      in_video_data_vld = '0;
      line_end          = '0;
      up_seen           = '0;
      for (int p = 0; p < num_pipes; p++) begin
         in_video_data[p] = '0;
         has_line[p]      = 1'b0;
         wait_release[p]  = 1'b0;
         refill[p]        = 0;
      end
      repeat (16) @(posedge aggre_clk);
      aggre_clk_rst_n <= 1'b1;
      repeat (2) @(posedge aggre_clk);
      finish_test("reset values", reset_errs);

      g0         = grant_errs;
      w0         = word_errs;
      s0         = state_errs;
      next_en_at = 0;
      aggre_mode <= mode_aggre_fixed;
      while (lines_sent < fixed_lines) begin
         @(posedge aggre_clk);
         if (lines_sent >= next_en_at) begin
            // at least one enabled pipe keeps lines flowing
            aggre_en   <= pipe_vec_t'($urandom) | (pipe_vec_t'(1) << ($urandom % num_pipes));
            next_en_at = next_en_at + lines_per_en;
         end
         drive_fixed_cycle(1'b1);
      end
      repeat (4) begin
         @(posedge aggre_clk);
         drive_fixed_cycle(1'b0);
      end
      finish_test("fixed line order", grant_errs - g0);
      finish_test("fixed data", word_errs - w0);

      g0 = grant_errs;
      w0 = word_errs;
      @(posedge aggre_clk);
      aggre_mode <= mode_aggre_async;
      drive_random_cycle();
      repeat (async_cycles - 1) begin
         @(posedge aggre_clk);
         drive_random_cycle();
      end
      finish_test("async filtering", (grant_errs - g0) + (word_errs - w0));
      finish_test("debug state", state_errs - s0);

      g0 = grant_errs + word_errs + state_errs;
      @(posedge aggre_clk);
      aggre_mode <= mode_off;
      repeat (off_cycles) begin
         @(posedge aggre_clk);
         drive_random_cycle();
      end
      aggre_mode <= mode_concat;
      repeat (off_cycles) begin
         @(posedge aggre_clk);
         drive_random_cycle();
      end
      @(negedge aggre_clk);
      finish_test("off modes", grant_errs + word_errs + state_errs - g0);

      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
               checks_done, reset_errs + grant_errs + word_errs + state_errs);
      if (tests_failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
